/* testbench/rx_serdes_tests.txt */
// Columns in hex: tap, bitslip writes, words to check, seed
// Taps above the last stage are clamped by the register block
0 0 10 00000001
0 0 14 0000a5a5
3 0 12 00001234
7 0 12 00beef01
0 1 12 00000077
5 3 12 0000c0de
0 9 12 00005a5a
f 0 12 00fa11ed
f 2 12 00000042
f 9 10 00013579
1 1 10 0002468a
0 0 10 000000ff
14 0 10 00777777
8 5 12 00abcdef
2 4 10 0000d00d

/* flist.f */
hdl/rx_serdes_pkg.sv
hdl/rx_cfg_if.sv
hdl/rx_cfg_regs.sv
hdl/rx_bit_delay.sv
hdl/rx_deserializer.sv
hdl/rx_word_capture.sv
hdl/rx_serdes_top.sv
testbench/rx_serdes_monitor.sv
testbench/tb_rx_serdes.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the receive deserializer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_rx_serdes \
    -o sim_rx_serdes || exit 1

out="$(./obj_dir/sim_rx_serdes)"
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && exit 0 || exit 1

/* testbench/tb_rx_serdes.sv */
// Receive deserializer testbench
// Reads tests from a data file, writes the config registers and drives
// random serial bits while the monitor checks every word

`default_nettype none

module tb_rx_serdes
    import rx_serdes_pkg::*;
;

    localparam int          WIDTH       = 10;
    localparam int          TAP_MAX     = 16;
    localparam int          LOCK_CYCLES = 255;
    localparam int          MAX_TESTS   = 32;
    localparam logic [31:0] SEED_BASE   = 32'hd7f2_5746;

    logic             clkGHz_clkbuf;
    logic             reset_buf_n;
    logic             enable_n;
    logic             data_i;
    logic             cfg_wr;
    cfg_addr_t        cfg_addr;
    cfg_data_t        cfg_wdata;
    logic [WIDTH-1:0] data_o;
    logic             word_strobe;
    logic             ready;
    int               words_checked;
    int               errors;
    int               pending;

    logic [31:0] tests [0:4*MAX_TESTS-1];   // tap, slips, words, seed
    logic [31:0] rnd_state;
    logic        pin_en_n;                  // Level driven on enable_n
    logic        timed_out;

    rx_serdes_top #(
        .WIDTH         (WIDTH),
        .TAP_MAX       (TAP_MAX),
        .LOCK_CYCLES   (LOCK_CYCLES)
    ) u_rx_serdes_top (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable_n      (enable_n),
        .data_i        (data_i),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .data_o        (data_o),
        .word_strobe   (word_strobe),
        .ready         (ready)
    );

    rx_serdes_monitor #(
        .WIDTH         (WIDTH),
        .TAP_MAX       (TAP_MAX),
        .LOCK_CYCLES   (LOCK_CYCLES)
    ) u_monitor (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable_n      (enable_n),
        .data_i        (data_i),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .data_o        (data_o),
        .word_strobe   (word_strobe),
        .ready         (ready),
        .words_checked (words_checked),
        .errors        (errors),
        .pending       (pending)
    );

    //**************************************************
    // Clock and helpers
    //**************************************************
    initial begin
        clkGHz_clkbuf = 1'b0;
        forever #4 clkGHz_clkbuf = ~clkGHz_clkbuf;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One falling edge, new random bit plus an optional write
    task automatic drive_cycle(input logic wr, input cfg_addr_t addr, input cfg_data_t wdata);
        @(negedge clkGHz_clkbuf);
        rnd_state = xorshift(rnd_state);
        data_i    = rnd_state[0];
        enable_n  = pin_en_n;
        cfg_wr    = wr;
        cfg_addr  = addr;
        cfg_wdata = wdata;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, ADDR_TAPS, '0);
    endtask

    //**************************************************
    // Test sequence
    //**************************************************
    initial begin
        int t;
        int waited;
        int limit;
        int words_before;
        int errs_before;
        int failed;
        reset_buf_n = 1'b0;
        enable_n    = 1'b1;
        data_i      = 1'b0;
        cfg_wr      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        pin_en_n    = 1'b1;
        rnd_state   = SEED_BASE;
        timed_out   = 1'b0;
        failed      = 0;
        t           = 0;
        foreach (tests[i]) tests[i] = 32'hffff_ffff;       // End marker
        $readmemh("testbench/rx_serdes_tests.txt", tests);
        repeat (2) @(negedge clkGHz_clkbuf);
        reset_buf_n = 1'b1;
        // Path runs through the lock wait, early words must be dropped
        drive_cycle(1'b1, ADDR_CTRL, 8'h01);
        pin_en_n = 1'b0;
        waited = 0;
        while (!ready && waited < LOCK_CYCLES + 20) begin  // Lock wait
            idle_cycles(1);
            waited++;
        end
        if (!ready) begin
            $display("Timeout: ready never rose after reset");
            timed_out = 1'b1;
        end
        while (!timed_out && t < MAX_TESTS && tests[4*t] != 32'hffff_ffff) begin
            rnd_state = SEED_BASE ^ tests[4*t+3];
            if (rnd_state == '0) rnd_state = SEED_BASE;
            words_before = words_checked;
            errs_before  = errors;
            pin_en_n = 1'b1;                                // Stop and realign
            idle_cycles(4);
            drive_cycle(1'b1, ADDR_TAPS, cfg_data_t'(tests[4*t]));
            drive_cycle(1'b1, ADDR_CTRL, 8'h01);
            pin_en_n = 1'b0;
            idle_cycles(3);
            for (int s = 0; s < int'(tests[4*t+1]); s++) begin
                drive_cycle(1'b1, ADDR_CTRL, 8'h03);        // Enable kept, one slip
                idle_cycles(2);
            end
            limit  = int'(tests[4*t+2]) * WIDTH * 2 + TAP_MAX + 50;
            waited = 0;
            while (words_checked < words_before + int'(tests[4*t+2]) && waited < limit) begin
                idle_cycles(1);
                waited++;
            end
            if (words_checked < words_before + int'(tests[4*t+2])) begin
                $display("Timeout: test %0d received too few words", t);
                timed_out = 1'b1;
            end
            if (errors != errs_before || timed_out) failed++;
            $display("Test %0d tap %0d slips %0d words %0d: %s", t, tests[4*t],
                     tests[4*t+1], tests[4*t+2],
                     (errors == errs_before && !timed_out) ? "ok" : "failed");
            t++;
        end
        // Drain words still in flight
        pin_en_n = 1'b1;
        waited   = 0;
        while (!timed_out && pending != 0 && waited < 100) begin
            idle_cycles(1);
            waited++;
        end
        if (pending != 0) begin
            $display("Predicted words never appeared on data_o: %0d", pending);
            timed_out = 1'b1;
        end
        $display("Tests %0d, failed %0d, words checked %0d, errors %0d",
                 t, failed, words_checked, errors);
        if (errors == 0 && failed == 0 && !timed_out && t > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rx_serdes_monitor.sv */
// Receive deserializer checker
// Logs the driven bits, rebuilds the delayed stream, predicts every word
// and compares it with the strobed data_o

`default_nettype none

module rx_serdes_monitor
    import rx_serdes_pkg::*;
#(
    parameter int WIDTH       = 10,
    parameter int TAP_MAX     = 16,
    parameter int LOCK_CYCLES = 255
) (
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    input  logic             enable_n,
    input  logic             data_i,
    input  logic             cfg_wr,
    input  cfg_addr_t        cfg_addr,
    input  cfg_data_t        cfg_wdata,
    input  logic [WIDTH-1:0] data_o,
    input  logic             word_strobe,
    input  logic             ready,
    output int               words_checked,     // Strobes compared
    output int               errors,
    output int               pending            // Words still in flight
);

    localparam int HIST = 64;                   // Bit log depth, beyond any tap

    logic             hist [0:HIST-1];          // Driven bits by cycle
    int               cycle;                    // Edges since reset release
    int               m_tap;                    // Model tap
    logic             m_en_ctrl;
    logic             m_en_pin;
    logic             m_slip;                   // Slip pulse seen next edge
    logic             m_seen;
    int               bit_pos;                  // Model bit counter
    logic [WIDTH-1:0] part;                     // Word being assembled
    logic             pend_word;                // Word done, capture next edge
    logic [WIDTH-1:0] pend_val;
    logic [WIDTH-1:0] exp_q [$];                // Words due on data_o

    assign pending = exp_q.size() + int'(pend_word);

    //**************************************************
    // Prediction and compare
    //**************************************************
    always @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        int               src;
        logic             dbit;
        logic             exp_ready;
        logic             m_en;
        logic [WIDTH-1:0] exp_w;
        if (!reset_buf_n) begin
            cycle     = 0;
            m_tap     = 0;
            m_en_ctrl = 1'b0;
            m_en_pin  = 1'b0;
            m_slip    = 1'b0;
            m_seen    = 1'b0;
            bit_pos   = 0;
            part      = '0;
            pend_word = 1'b0;
            pend_val  = '0;
            exp_q.delete();
        end else begin
            exp_ready = (cycle >= LOCK_CYCLES);         // Lock wait rule
            m_en      = m_en_ctrl && m_en_pin;
            if (ready !== exp_ready) begin
                $display("Mismatch at %0t: ready expected %b received %b",
                         $time, exp_ready, ready);
                errors++;
            end
            if (word_strobe === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: word strobe with no predicted word", $time);
                    errors++;
                end else begin
                    exp_w = exp_q.pop_front();
                    words_checked++;
                    if (data_o !== exp_w) begin
                        $display("Mismatch at %0t: expected %h received %h",
                                 $time, exp_w, data_o);
                        errors++;
                    end
                end
            end
            if (!exp_ready && data_o !== '0) begin
                $display("Mismatch at %0t: data_o expected 0 before ready, received %h",
                         $time, data_o);
                errors++;
            end
            // Capture stage takes the word only once ready
            if (pend_word && exp_ready) begin
                exp_q.push_back(pend_val);
            end
            pend_word = 1'b0;
            // Bit sampled on edge n is shifted in on edge n+2+tap
            hist[cycle % HIST] = data_i;
            src  = cycle - 2 - m_tap;
            dbit = (src >= 0) ? hist[src % HIST] : 1'b0;
            if (!m_en) begin
                bit_pos = 0;                            // Disabled, realign
            end else if (m_slip) begin
                bit_pos = bit_pos;                      // Slip drops the bit
            end else if (m_seen) begin
                bit_pos = 0;                            // Any write realigns
            end else begin
                part[bit_pos] = dbit;                   // LSB first
                if (bit_pos == WIDTH - 1) begin
                    pend_word = 1'b1;
                    pend_val  = part;
                    bit_pos   = 0;
                end else begin
                    bit_pos++;
                end
            end
            // Register writes act for the following edges
            if (cfg_wr && cfg_addr == ADDR_CTRL) begin
                m_en_ctrl = cfg_wdata[CTRL_EN_BIT];
            end
            if (cfg_wr && cfg_addr == ADDR_TAPS) begin
                m_tap = (int'(cfg_wdata) > TAP_MAX - 1) ? TAP_MAX - 1 : int'(cfg_wdata);
            end
            m_slip   = cfg_wr && cfg_addr == ADDR_CTRL && cfg_wdata[CTRL_SLIP_BIT];
            m_seen   = cfg_wr;
            m_en_pin = !enable_n;
            cycle++;
        end
    end

endmodule

`default_nettype wire

/* hdl/rx_serdes_top.sv */
// Receive deserializer top level
// Config registers, bit delay, deserializer and lock-gated capture
// on the single fast clock

`default_nettype none

module rx_serdes_top
    import rx_serdes_pkg::*;
#(
    parameter int WIDTH       = 10,         // Deserialization width
    parameter int TAP_MAX     = 16,         // Delay taps
    parameter int LOCK_CYCLES = 255         // Lock wait length
) (
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    input  logic             enable_n,      // Active low pin enable
    input  logic             data_i,        // Serial data
    input  logic             cfg_wr,
    input  cfg_addr_t        cfg_addr,
    input  cfg_data_t        cfg_wdata,
    output logic [WIDTH-1:0] data_o,
    output logic             word_strobe,   // Aligned with data_o
    output logic             ready
);

    logic             bit_dly;      // Delay line output
    logic [WIDTH-1:0] des_word;     // Deserializer word
    logic             des_strobe;   // Deserializer word strobe

    //**************************************************
    // Configuration
    //**************************************************
    rx_cfg_if u_cfg_if ();

    rx_cfg_regs #(
        .TAP_MAX       (TAP_MAX)
    ) u_cfg_regs (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable_n      (enable_n),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg           (u_cfg_if.src)
    );

    //**************************************************
    // Receive path
    //**************************************************
    rx_bit_delay #(
        .TAP_MAX       (TAP_MAX)
    ) u_bit_delay (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .data_i        (data_i),
        .cfg           (u_cfg_if.dly),
        .bit_dly       (bit_dly)
    );

    rx_deserializer #(
        .WIDTH         (WIDTH)
    ) u_deserializer (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .bit_dly       (bit_dly),
        .cfg           (u_cfg_if.des),
        .word          (des_word),
        .word_strobe   (des_strobe)
    );

    rx_word_capture #(
        .WIDTH         (WIDTH),
        .LOCK_CYCLES   (LOCK_CYCLES)
    ) u_word_capture (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .word          (des_word),
        .word_strobe   (des_strobe),
        .data_o        (data_o),
        .data_strobe   (word_strobe),   // Registered copy goes out
        .ready         (ready)
    );

endmodule

`default_nettype wire

/* hdl/rx_word_capture.sv */
// Lock-wait counter and gated output word register
// Words are passed to data_o only once the lock wait has expired

`default_nettype none

module rx_word_capture #(
    parameter int WIDTH       = 10,         // Word width
    parameter int LOCK_CYCLES = 255         // Cycles before ready
) (
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    input  logic [WIDTH-1:0] word,          // From the deserializer
    input  logic             word_strobe,
    output logic [WIDTH-1:0] data_o,        // Held between strobes
    output logic             data_strobe,   // Aligned with data_o
    output logic             ready
);

    localparam int LOCK_W = $clog2(LOCK_CYCLES + 1);

    typedef logic [LOCK_W-1:0] lock_cnt_t;

    localparam lock_cnt_t LOCK_LAST = lock_cnt_t'(LOCK_CYCLES);

    lock_cnt_t lock_cnt;        // Saturating wait counter
    logic      take_word;

    assign ready     = (lock_cnt == LOCK_LAST);
    assign take_word = word_strobe && ready;    // Early words are lost

    //**************************************************
    // Lock wait
    //**************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            lock_cnt <= '0;
        end else if (!ready) begin
            lock_cnt <= lock_cnt + 1'b1;    // Stops at LOCK_CYCLES
        end
    end

    //**************************************************
    // Output register
    //**************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_o      <= '0;
            data_strobe <= 1'b0;
        end else begin
            data_strobe <= take_word;
            if (take_word) begin
                data_o <= word;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rx_deserializer.sv */
// Serial-to-parallel shifter for the receive path
// Fills words LSB first under a bit counter, strobes each finished word
// and applies bitslip by stalling the counter for one bit

`default_nettype none

module rx_deserializer #(
    parameter int WIDTH = 10                // Deserialization width, 3 to 10
) (
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    input  logic             bit_dly,       // Bit from the delay line
    rx_cfg_if.des            cfg,
    output logic [WIDTH-1:0] word,          // Completed word
    output logic             word_strobe    // One cycle per word
);

    localparam int CNT_W = $clog2(WIDTH);

    typedef logic [CNT_W-1:0] bit_cnt_t;
    typedef logic [WIDTH-1:0] word_t;

    localparam bit_cnt_t CNT_LAST = bit_cnt_t'(WIDTH - 1);

    bit_cnt_t bit_cnt;          // Position of the next bit in the word
    word_t    asm_q;            // Assembly shift register
    word_t    asm_next;
    logic     take_bit;         // Bit counted this cycle
    logic     word_done;        // Last bit of a word counted

    //**************************************************
    // Bit acceptance
    //**************************************************
    // A slip write also raises cfg_seen in the same cycle.
    // Slip is checked first so that repeated slips add up.
    assign take_bit  = cfg.rx_en && !cfg.bitslip && !cfg.cfg_seen;
    assign word_done = take_bit && (bit_cnt == CNT_LAST);
    assign asm_next  = {bit_dly, asm_q[WIDTH-1:1]};    // New bit at MSB

    //**************************************************
    // Bit counter
    //**************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt <= '0;
        end else if (!cfg.rx_en) begin
            bit_cnt <= '0;                  // Disabled, restart alignment
        end else if (cfg.bitslip) begin
            bit_cnt <= bit_cnt;             // Stall, bit is dropped
        end else if (cfg.cfg_seen) begin
            bit_cnt <= '0;                  // Any write restarts
        end else if (word_done) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Assembly register, WIDTH shifts push the first bit down to bit 0
    always_ff @(posedge clkGHz_clkbuf) begin
        if (take_bit) begin
            asm_q <= asm_next;
        end
    end

    //**************************************************
    // Word output
    //**************************************************
    always_ff @(posedge clkGHz_clkbuf) begin
        if (word_done) begin
            word <= asm_next;               // Include the last bit
        end
    end

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            word_strobe <= 1'b0;
        end else begin
            word_strobe <= word_done;       // Aligned with word
        end
    end

endmodule

`default_nettype wire

/* hdl/rx_bit_delay.sv */
// Input bit register and tap-selectable delay line
// Bit sampled on edge n leaves the line after edge n+1+tap_sel

`default_nettype none

module rx_bit_delay #(
    parameter int TAP_MAX = 16              // Number of delay stages
) (
    input  logic  clkGHz_clkbuf,
    input  logic  reset_buf_n,
    input  logic  data_i,                   // Fast serial input
    rx_cfg_if.dly cfg,
    output logic  bit_dly                   // Delayed bit to deserializer
);

    logic               bit_q;              // Input capture flop
    logic [TAP_MAX-1:0] chain_q;            // Stage 0 is the shortest tap

    //**************************************************
    // Capture and shift chain
    //**************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_q   <= 1'b0;
            chain_q <= '0;                  // No stale bits after reset
        end else begin
            bit_q   <= data_i;
            chain_q <= {chain_q[TAP_MAX-2:0], bit_q};   // Push toward MSB
        end
    end

    // Tap mux
    assign bit_dly = chain_q[cfg.tap_sel];

endmodule

`default_nettype wire

/* hdl/rx_cfg_regs.sv */
// Receive path configuration registers
// Holds the delay tap and enable bit, turns control writes into slip pulses
// and merges the registered enable pin into rx_en

`default_nettype none

module rx_cfg_regs
    import rx_serdes_pkg::*;
#(
    parameter int TAP_MAX = 16              // Delay line depth
) (
    input  logic      clkGHz_clkbuf,
    input  logic      reset_buf_n,
    input  logic      enable_n,             // Pin enable, active low
    input  logic      cfg_wr,               // Write strobe
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    rx_cfg_if.src     cfg
);

    // Highest reachable tap, in tap and write data widths
    localparam tap_t      TAP_LAST   = tap_t'(TAP_MAX - 1);
    localparam cfg_data_t TAP_LAST_W = cfg_data_t'(TAP_MAX - 1);

    tap_t tap_q;            // Stored tap
    logic en_ctrl_q;        // Stored enable bit
    logic en_pin_q;         // Registered inverse of enable_n
    logic slip_q;           // Bitslip pulse
    logic seen_q;           // Any-write pulse
    logic wr_taps;
    logic wr_ctrl;

    //**************************************************
    // Write decode
    //**************************************************
    assign wr_taps = cfg_wr && (cfg_addr == ADDR_TAPS);
    assign wr_ctrl = cfg_wr && (cfg_addr == ADDR_CTRL);

    //**************************************************
    // Stored registers
    //**************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            tap_q     <= '0;
            en_ctrl_q <= 1'b0;
        end else begin
            if (wr_taps) begin
                if (cfg_wdata > TAP_LAST_W) begin
                    tap_q <= TAP_LAST;          // Clamp to last stage
                end else begin
                    tap_q <= tap_t'(cfg_wdata);
                end
            end
            if (wr_ctrl) begin
                en_ctrl_q <= cfg_wdata[CTRL_EN_BIT];
            end
        end
    end

    //**************************************************
    // Pulses and pin enable
    //**************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            slip_q   <= 1'b0;
            seen_q   <= 1'b0;
            en_pin_q <= 1'b0;
        end else begin
            slip_q   <= wr_ctrl && cfg_wdata[CTRL_SLIP_BIT];    // Not stored
            seen_q   <= cfg_wr;                                 // Any address
            en_pin_q <= ~enable_n;
        end
    end

    // Outputs onto the config bundle
    assign cfg.tap_sel  = tap_q;
    assign cfg.rx_en    = en_ctrl_q & en_pin_q;     // Both enables needed
    assign cfg.bitslip  = slip_q;
    assign cfg.cfg_seen = seen_q;

endmodule

`default_nettype wire

/* hdl/rx_cfg_if.sv */
// Configuration bundle from the register block to the receive path
// Tap select and enable are levels, bitslip and cfg_seen are pulses

`default_nettype none

interface rx_cfg_if
    import rx_serdes_pkg::*;
();

    tap_t tap_sel;      // Delay tap for the bit delay line
    logic rx_en;        // Receive enable level
    logic bitslip;      // One-cycle slip request
    logic cfg_seen;     // One-cycle pulse on any write

    // Register block side
    modport src (
        output tap_sel,
        output rx_en,
        output bitslip,
        output cfg_seen
    );

    // Delay line only needs the tap
    modport dly (
        input tap_sel
    );

    // Deserializer control
    modport des (
        input rx_en,
        input bitslip,
        input cfg_seen
    );

endinterface

`default_nettype wire

/* hdl/rx_serdes_pkg.sv */
// Receive deserializer shared types
// Tap, register address and register data widths plus the register map

`default_nettype none

package rx_serdes_pkg;

    //**************************************************
    // Meaningful widths
    //**************************************************
    typedef logic [3:0] tap_t;          // Delay line tap select
    typedef logic [1:0] cfg_addr_t;     // Config register address
    typedef logic [7:0] cfg_data_t;     // Config write data

    //**************************************************
    // Register map
    //**************************************************
    localparam cfg_addr_t ADDR_TAPS = 2'd0;     // Delay tap register
    localparam cfg_addr_t ADDR_CTRL = 2'd1;     // Enable and bitslip

    // Control register bit positions
    localparam int CTRL_EN_BIT   = 0;           // Stored enable level
    localparam int CTRL_SLIP_BIT = 1;           // Write 1 for one slip

endpackage

`default_nettype wire
